/* include/rr_macros.svh */
`ifndef RR_MACROS_SVH
`define RR_MACROS_SVH

//////////////////////////////
// Trace word geometry
//////////////////////////////
// Payload field of one log entry, wide enough for the widest request
`define RR_LOG_PAYLOAD_W 64
// Channels merged into the trace, in bus order sda then ocl
`define RR_NUM_CHANNELS 2

//////////////////////////////
// Buffering and flow control
//////////////////////////////
// Log queue per recorder
`define RR_LOG_FIFO_DEPTH 4
// Decoder buffer, equal to the replay credits storage starts with
`define RR_REPLAY_FIFO_DEPTH 4
// Trace credits held by the merger after reset
`define RR_TRACE_CREDITS 4
// Mode staging so every channel switches in the same cycle
`define RR_MODE_STAGES 2

`endif

/* logic/rr_pkg.sv */
`default_nettype none
`include "rr_macros.svh"

package rr_pkg;

  // Channel id, order follows the logging merge tree
  typedef enum logic [0:0] {
    CH_SDA = 1'b0,
    CH_OCL = 1'b1
  } rr_chan_e;

  // sda write request, 20-bit address space
  typedef struct packed {
    logic [19:0] addr;
    logic [31:0] data;
  } sda_req_t;

  // ocl write request
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } ocl_req_t;

  // One log entry, request zero-extended into the low payload bits
  typedef struct packed {
    rr_chan_e                      chan;
    logic [`RR_LOG_PAYLOAD_W-1:0]  payload;
  } rr_trace_word_t;

  // One beat on a credit-controlled trace stream
  typedef struct packed {
    logic           valid;
    rr_trace_word_t word;
  } rr_trace_stream_t;

  // Record/replay mode bits
  typedef struct packed {
    logic record_en;
    logic replay_en;
  } rr_mode_t;

endpackage

`default_nettype wire

/* logic/rr_trace_decoder.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rr_macros.svh"

module rr_trace_decoder (
  input  wire logic                                 i_clk,
  input  wire logic                                 i_rst_n,
  input  wire rr_pkg::rr_trace_stream_t             i_replay_trace,
  output logic                                      o_replay_credit,
  output logic [`RR_NUM_CHANNELS-1:0]               o_entry_valid,
  output rr_pkg::rr_trace_word_t                    o_entry,
  input  wire logic [`RR_NUM_CHANNELS-1:0]          i_entry_ready
);

  localparam int DEPTH = `RR_REPLAY_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Word buffer, sized to the credits storage holds so it never overflows
  rr_pkg::rr_trace_word_t fifo_mem [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic                   push;
  logic                   pop;
  logic                   credit_q;
  rr_pkg::rr_trace_word_t head_word;

  // Storage only sends while it holds a credit
  assign push      = i_replay_trace.valid;
  assign head_word = fifo_mem[rd_ptr_q];
  assign o_entry   = head_word;

  // Only the head's own channel sees valid, so trace order is kept
  for (genvar ch = 0; ch < `RR_NUM_CHANNELS; ch++) begin : g_dispatch
    assign o_entry_valid[ch] = (count_q != '0) &&
                               (head_word.chan == rr_pkg::rr_chan_e'(ch));
  end

  // Head leaves when its channel takes it
  assign pop = |(o_entry_valid & i_entry_ready);

  always_ff @(posedge i_clk) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= i_replay_trace.word;
    end
  end

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + CNT_W'(push) - CNT_W'(pop);
      // One credit back per dispatched word
      credit_q <= pop;
    end
  end

  assign o_replay_credit = credit_q;

endmodule

`default_nettype wire

/* logic/rr_channel_replayer.sv */
`timescale 1ns/1ns
`default_nettype none

module rr_channel_replayer #(
  parameter type T_PAYLOAD = rr_pkg::sda_req_t
) (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst_n,
  input  wire logic                   i_entry_valid,
  input  wire rr_pkg::rr_trace_word_t i_entry,
  output logic                        o_entry_ready,
  output logic                        o_rep_valid,
  output T_PAYLOAD                    o_rep_req,
  input  wire logic                   i_rep_ready
);

  localparam int PAYLOAD_W = $bits(T_PAYLOAD);

  // Single entry holding register
  logic     full_q;
  T_PAYLOAD req_q;

  // Take a new entry only while empty
  assign o_entry_ready = !full_q;

  always_ff @(posedge i_clk) begin
    if (i_entry_valid && o_entry_ready) begin
      // Drop the zero-extension bits above the request
      req_q <= i_entry.payload[PAYLOAD_W-1:0];
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      full_q <= 1'b0;
    end else if (i_entry_valid && o_entry_ready) begin
      full_q <= 1'b1;
    end else if (full_q && i_rep_ready) begin
      // CL side accepted the replayed request
      full_q <= 1'b0;
    end
  end

  // Held on the CL side until accepted
  assign o_rep_valid = full_q;
  assign o_rep_req   = req_q;

endmodule

`default_nettype wire

/* logic/rr_channel_recorder.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rr_macros.svh"

module rr_channel_recorder #(
  parameter type              T_PAYLOAD = rr_pkg::sda_req_t,
  parameter rr_pkg::rr_chan_e CHAN      = rr_pkg::CH_SDA
) (
  input  wire logic            i_clk,
  input  wire logic            i_rst_n,
  input  wire rr_pkg::rr_mode_t i_mode,
  input  wire logic            i_sh_valid,
  input  wire T_PAYLOAD        i_sh_req,
  output logic                 o_sh_ready,
  input  wire logic            i_rep_valid,
  input  wire T_PAYLOAD        i_rep_req,
  output logic                 o_rep_ready,
  output logic                 o_cl_valid,
  output T_PAYLOAD             o_cl_req,
  input  wire logic            i_cl_ready,
  output logic                 o_log_valid,
  output rr_pkg::rr_trace_word_t o_log_word,
  input  wire logic            i_log_pop
);

  localparam int DEPTH     = `RR_LOG_FIFO_DEPTH;
  localparam int PTR_W     = $clog2(DEPTH);
  localparam int CNT_W     = $clog2(DEPTH + 1);
  localparam int PAYLOAD_W = $bits(T_PAYLOAD);

  rr_pkg::rr_trace_word_t log_mem [DEPTH];
  rr_pkg::rr_trace_word_t log_entry;
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic                   blocked;
  logic                   push;

  //////////////////////////////
  // Source select
  //////////////////////////////
  // Stall the channel rather than lose a log entry
  assign blocked = i_mode.record_en && (count_q == CNT_W'(DEPTH));

  assign o_cl_valid  = !blocked && (i_mode.replay_en ? i_rep_valid : i_sh_valid);
  assign o_cl_req    = i_mode.replay_en ? i_rep_req : i_sh_req;
  // Unselected source sees ready low
  assign o_sh_ready  = !blocked && !i_mode.replay_en && i_cl_ready;
  assign o_rep_ready = !blocked && i_mode.replay_en && i_cl_ready;

  //////////////////////////////
  // Log queue
  //////////////////////////////
  // Log what the CL actually accepted
  assign push = i_mode.record_en && o_cl_valid && i_cl_ready;

  always_comb begin
    log_entry                      = '0;
    log_entry.chan                 = CHAN;
    log_entry.payload[PAYLOAD_W-1:0] = o_cl_req;
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      log_mem[wr_ptr_q] <= log_entry;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (i_log_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(i_log_pop);
    end
  end

  // Head visible from the cycle after the push
  assign o_log_valid = (count_q != '0);
  assign o_log_word  = log_mem[rd_ptr_q];

endmodule

`default_nettype wire

/* logic/rr_trace_merger.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rr_macros.svh"

module rr_trace_merger (
  input  wire logic                                          i_clk,
  input  wire logic                                          i_rst_n,
  input  wire logic [`RR_NUM_CHANNELS-1:0]                   i_log_valid,
  input  wire rr_pkg::rr_trace_word_t [`RR_NUM_CHANNELS-1:0] i_log_word,
  output logic [`RR_NUM_CHANNELS-1:0]                        o_log_pop,
  output rr_pkg::rr_trace_stream_t                           o_trace,
  input  wire logic                                          i_trace_credit
);

  localparam int N     = `RR_NUM_CHANNELS;
  localparam int IDX_W = $clog2(N);
  localparam int CRD_W = $clog2(`RR_TRACE_CREDITS + 1);

  logic [CRD_W-1:0]       credit_q;
  logic [IDX_W-1:0]       last_q;
  logic [IDX_W-1:0]       grant_idx;
  logic                   grant_valid;
  logic                   send;
  logic                   trace_valid_q;
  rr_pkg::rr_trace_word_t trace_word_q;

  //////////////////////////////
  // Round-robin arbitration
  //////////////////////////////
  // Scan starts one past the last winner
  always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant_idx   = last_q;
    for (int k = 1; k <= N; k++) begin
      idx = (int'(last_q) + k) % N;
      if (!grant_valid && i_log_valid[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = IDX_W'(idx);
      end
    end
  end

  // No beat leaves without a credit
  assign send = grant_valid && (credit_q != '0);

  always_comb begin
    o_log_pop            = '0;
    o_log_pop[grant_idx] = send;
  end

  //////////////////////////////
  // Output beat and credits
  //////////////////////////////
  always_ff @(posedge i_clk) begin
    if (send) begin
      trace_word_q <= i_log_word[grant_idx];
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      trace_valid_q <= 1'b0;
      last_q        <= IDX_W'(N - 1);
      credit_q      <= CRD_W'(`RR_TRACE_CREDITS);
    end else begin
      trace_valid_q <= send;
      if (send) begin
        last_q <= grant_idx;
      end
      // Spend one per beat, regain one per returned pulse
      credit_q <= credit_q - CRD_W'(send) + CRD_W'(i_trace_credit);
    end
  end

  assign o_trace.valid = trace_valid_q;
  assign o_trace.word  = trace_word_q;

endmodule

`default_nettype wire

/* logic/rr_wrapper.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rr_macros.svh"

module rr_wrapper (
  input  wire logic                     i_clk,
  input  wire logic                     i_rst_n,
  input  wire logic                     i_record_en,
  input  wire logic                     i_replay_en,
  // Shell side
  input  wire logic                     i_sda_req_valid,
  input  wire rr_pkg::sda_req_t         i_sda_req,
  output logic                          o_sda_req_ready,
  input  wire logic                     i_ocl_req_valid,
  input  wire rr_pkg::ocl_req_t         i_ocl_req,
  output logic                          o_ocl_req_ready,
  // CL side
  output logic                          o_cl_sda_req_valid,
  output rr_pkg::sda_req_t              o_cl_sda_req,
  input  wire logic                     i_cl_sda_ready,
  output logic                          o_cl_ocl_req_valid,
  output rr_pkg::ocl_req_t              o_cl_ocl_req,
  input  wire logic                     i_cl_ocl_ready,
  // Storage side
  output rr_pkg::rr_trace_stream_t      o_trace,
  input  wire logic                     i_trace_credit,
  input  wire rr_pkg::rr_trace_stream_t i_replay_trace,
  output logic                          o_replay_credit
);

  localparam int STAGES = `RR_MODE_STAGES;
  // Replay with an empty decoder keeps the shell blocked while the pipe fills
  localparam rr_pkg::rr_mode_t MODE_RESET = '{record_en: 1'b0, replay_en: 1'b1};

  rr_pkg::rr_mode_t                          mode_in;
  rr_pkg::rr_mode_t                          mode_pipe_q [STAGES];
  logic [`RR_NUM_CHANNELS-1:0]               entry_valid;
  logic [`RR_NUM_CHANNELS-1:0]               entry_ready;
  rr_pkg::rr_trace_word_t                    entry;
  logic                                      sda_rep_valid;
  logic                                      sda_rep_ready;
  rr_pkg::sda_req_t                          sda_rep_req;
  logic                                      ocl_rep_valid;
  logic                                      ocl_rep_ready;
  rr_pkg::ocl_req_t                          ocl_rep_req;
  logic [`RR_NUM_CHANNELS-1:0]               log_valid;
  logic [`RR_NUM_CHANNELS-1:0]               log_pop;
  rr_pkg::rr_trace_word_t [`RR_NUM_CHANNELS-1:0] log_word;

  //////////////////////////////
  // Mode pipeline
  //////////////////////////////
  assign mode_in.record_en = i_record_en;
  assign mode_in.replay_en = i_replay_en;

  // All channels see the last stage in the same cycle
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int s = 0; s < STAGES; s++) begin
        mode_pipe_q[s] <= MODE_RESET;
      end
    end else begin
      mode_pipe_q[0] <= mode_in;
      for (int s = 1; s < STAGES; s++) begin
        mode_pipe_q[s] <= mode_pipe_q[s-1];
      end
    end
  end

  //////////////////////////////
  // Replay path
  //////////////////////////////
  rr_trace_decoder u_decoder (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_replay_trace  (i_replay_trace),
    .o_replay_credit (o_replay_credit),
    .o_entry_valid   (entry_valid),
    .o_entry         (entry),
    .i_entry_ready   (entry_ready)
  );

  rr_channel_replayer #(.T_PAYLOAD(rr_pkg::sda_req_t)) u_sda_replayer (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_entry_valid (entry_valid[rr_pkg::CH_SDA]),
    .i_entry       (entry),
    .o_entry_ready (entry_ready[rr_pkg::CH_SDA]),
    .o_rep_valid   (sda_rep_valid),
    .o_rep_req     (sda_rep_req),
    .i_rep_ready   (sda_rep_ready)
  );

  rr_channel_replayer #(.T_PAYLOAD(rr_pkg::ocl_req_t)) u_ocl_replayer (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_entry_valid (entry_valid[rr_pkg::CH_OCL]),
    .i_entry       (entry),
    .o_entry_ready (entry_ready[rr_pkg::CH_OCL]),
    .o_rep_valid   (ocl_rep_valid),
    .o_rep_req     (ocl_rep_req),
    .i_rep_ready   (ocl_rep_ready)
  );

  //////////////////////////////
  // Record path
  //////////////////////////////
  rr_channel_recorder #(
    .T_PAYLOAD (rr_pkg::sda_req_t),
    .CHAN      (rr_pkg::CH_SDA)
  ) u_sda_recorder (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_mode      (mode_pipe_q[STAGES-1]),
    .i_sh_valid  (i_sda_req_valid),
    .i_sh_req    (i_sda_req),
    .o_sh_ready  (o_sda_req_ready),
    .i_rep_valid (sda_rep_valid),
    .i_rep_req   (sda_rep_req),
    .o_rep_ready (sda_rep_ready),
    .o_cl_valid  (o_cl_sda_req_valid),
    .o_cl_req    (o_cl_sda_req),
    .i_cl_ready  (i_cl_sda_ready),
    .o_log_valid (log_valid[rr_pkg::CH_SDA]),
    .o_log_word  (log_word[rr_pkg::CH_SDA]),
    .i_log_pop   (log_pop[rr_pkg::CH_SDA])
  );

  rr_channel_recorder #(
    .T_PAYLOAD (rr_pkg::ocl_req_t),
    .CHAN      (rr_pkg::CH_OCL)
  ) u_ocl_recorder (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_mode      (mode_pipe_q[STAGES-1]),
    .i_sh_valid  (i_ocl_req_valid),
    .i_sh_req    (i_ocl_req),
    .o_sh_ready  (o_ocl_req_ready),
    .i_rep_valid (ocl_rep_valid),
    .i_rep_req   (ocl_rep_req),
    .o_rep_ready (ocl_rep_ready),
    .o_cl_valid  (o_cl_ocl_req_valid),
    .o_cl_req    (o_cl_ocl_req),
    .i_cl_ready  (i_cl_ocl_ready),
    .o_log_valid (log_valid[rr_pkg::CH_OCL]),
    .o_log_word  (log_word[rr_pkg::CH_OCL]),
    .i_log_pop   (log_pop[rr_pkg::CH_OCL])
  );

  // Both log queues into one trace stream
  rr_trace_merger u_merger (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_log_valid    (log_valid),
    .i_log_word     (log_word),
    .o_log_pop      (log_pop),
    .o_trace        (o_trace),
    .i_trace_credit (i_trace_credit)
  );

endmodule

`default_nettype wire

/* testbench/tb_rr_wrapper.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rr_macros.svh"

module tb_rr_wrapper;

  localparam int N_REC       = 16;
  localparam int N_BP        = 12;
  localparam int N_REP       = 16;
  localparam int N_RR        = 16;
  localparam int N_OFF       = 12;
  localparam int TOTAL_REQ   = 2 * N_REC + 2 * N_BP + N_REP + N_RR + 2 * N_OFF;
  localparam int CYCLE_LIMIT = 20 * TOTAL_REQ + 200;

  logic                     clk;
  logic                     rst_n;
  logic                     record_en;
  logic                     replay_en;
  logic                     sda_valid;
  rr_pkg::sda_req_t         sda_req;
  logic                     sda_ready;
  logic                     ocl_valid;
  rr_pkg::ocl_req_t         ocl_req;
  logic                     ocl_ready;
  logic                     cl_sda_valid;
  rr_pkg::sda_req_t         cl_sda_req;
  logic                     cl_sda_ready;
  logic                     cl_ocl_valid;
  rr_pkg::ocl_req_t         cl_ocl_req;
  logic                     cl_ocl_ready;
  rr_pkg::rr_trace_stream_t trace_out;
  logic                     trace_credit;
  rr_pkg::rr_trace_stream_t replay_in;
  logic                     replay_credit;

  // Stimulus and expected-value queues per channel
  rr_pkg::sda_req_t       sda_stim_q[$];
  rr_pkg::ocl_req_t       ocl_stim_q[$];
  rr_pkg::rr_trace_word_t feed_q[$];
  rr_pkg::sda_req_t       exp_sda_cl_q[$];
  rr_pkg::ocl_req_t       exp_ocl_cl_q[$];
  rr_pkg::rr_trace_word_t exp_sda_trace_q[$];
  rr_pkg::rr_trace_word_t exp_ocl_trace_q[$];

  logic credit_en;
  logic rec_active;
  logic rep_active;
  logic stall_seen;
  int   beats_seen;
  int   credits_seen;
  int   words_fed;
  int   credit_pulses;
  int   cycles;
  int   errors;
  int   owed;
  int   rep_credits = `RR_REPLAY_FIFO_DEPTH;

  rr_wrapper i_dut (
    .i_clk              (clk),
    .i_rst_n            (rst_n),
    .i_record_en        (record_en),
    .i_replay_en        (replay_en),
    .i_sda_req_valid    (sda_valid),
    .i_sda_req          (sda_req),
    .o_sda_req_ready    (sda_ready),
    .i_ocl_req_valid    (ocl_valid),
    .i_ocl_req          (ocl_req),
    .o_ocl_req_ready    (ocl_ready),
    .o_cl_sda_req_valid (cl_sda_valid),
    .o_cl_sda_req       (cl_sda_req),
    .i_cl_sda_ready     (cl_sda_ready),
    .o_cl_ocl_req_valid (cl_ocl_valid),
    .o_cl_ocl_req       (cl_ocl_req),
    .i_cl_ocl_ready     (cl_ocl_ready),
    .o_trace            (trace_out),
    .i_trace_credit     (trace_credit),
    .i_replay_trace     (replay_in),
    .o_replay_credit    (replay_credit)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  //////////////////////////////
  // Reference model and checks
  //////////////////////////////
  // Request zero-extended into the payload with the address above the data
  function automatic rr_pkg::rr_trace_word_t trace_of(input rr_pkg::rr_chan_e chan,
                                                      input logic [31:0] addr,
                                                      input logic [31:0] data);
    rr_pkg::rr_trace_word_t w;
    w.chan    = chan;
    w.payload = {addr, data};
    return w;
  endfunction

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    abort_run();
  endtask

  task automatic check(input string name, input logic [64:0] expected,
                       input logic [64:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  //////////////////////////////
  // Stimulus builders
  //////////////////////////////
  task automatic send_shell(input int n, input bit rec);
    rr_pkg::sda_req_t s;
    rr_pkg::ocl_req_t o;
    for (int i = 0; i < n; i++) begin
      s.addr = 20'($urandom());
      s.data = $urandom();
      o.addr = $urandom();
      o.data = $urandom();
      sda_stim_q.push_back(s);
      ocl_stim_q.push_back(o);
      exp_sda_cl_q.push_back(s);
      exp_ocl_cl_q.push_back(o);
      if (rec) begin
        exp_sda_trace_q.push_back(trace_of(rr_pkg::CH_SDA, {12'h0, s.addr}, s.data));
        exp_ocl_trace_q.push_back(trace_of(rr_pkg::CH_OCL, o.addr, o.data));
      end
    end
  endtask

  // Wide words keep junk above the sda request to exercise truncation
  task automatic feed_replay(input int n, input bit wide, input bit rec);
    rr_pkg::rr_trace_word_t w;
    rr_pkg::sda_req_t       s;
    rr_pkg::ocl_req_t       o;
    for (int i = 0; i < n; i++) begin
      w.chan    = ($urandom_range(1) == 1) ? rr_pkg::CH_OCL : rr_pkg::CH_SDA;
      w.payload = {$urandom(), $urandom()};
      if (w.chan == rr_pkg::CH_SDA) begin
        if (!wide) begin
          w.payload[63:52] = '0;
        end
        s.addr = w.payload[51:32];
        s.data = w.payload[31:0];
        exp_sda_cl_q.push_back(s);
        if (rec) begin
          exp_sda_trace_q.push_back(trace_of(rr_pkg::CH_SDA, {12'h0, s.addr}, s.data));
        end
      end else begin
        o.addr = w.payload[63:32];
        o.data = w.payload[31:0];
        exp_ocl_cl_q.push_back(o);
        if (rec) begin
          exp_ocl_trace_q.push_back(trace_of(rr_pkg::CH_OCL, o.addr, o.data));
        end
      end
      feed_q.push_back(w);
      words_fed++;
    end
  endtask

  // Mode changes only land while every channel is idle
  task automatic set_mode(input bit rec, input bit rep);
    if (!rep) begin
      rep_active = 1'b0;
    end
    @(posedge clk);
    record_en <= rec;
    replay_en <= rep;
    repeat (`RR_MODE_STAGES + 1) @(posedge clk);
    rec_active = rec;
    rep_active = rep;
  endtask

  task automatic wait_idle();
    while (sda_stim_q.size() != 0 || ocl_stim_q.size() != 0 || feed_q.size() != 0 ||
           sda_valid || ocl_valid || replay_in.valid ||
           exp_sda_cl_q.size() != 0 || exp_ocl_cl_q.size() != 0 ||
           exp_sda_trace_q.size() != 0 || exp_ocl_trace_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  //////////////////////////////
  // Shell, CL and storage models
  //////////////////////////////
  // Next request goes out once the current one is taken
  always @(posedge clk) begin
    if (rst_n) begin
      if (!sda_valid || sda_ready) begin
        if (sda_stim_q.size() > 0 && $urandom_range(3) != 0) begin
          sda_valid <= 1'b1;
          sda_req   <= sda_stim_q.pop_front();
        end else begin
          sda_valid <= 1'b0;
        end
      end
      if (!ocl_valid || ocl_ready) begin
        if (ocl_stim_q.size() > 0 && $urandom_range(3) != 0) begin
          ocl_valid <= 1'b1;
          ocl_req   <= ocl_stim_q.pop_front();
        end else begin
          ocl_valid <= 1'b0;
        end
      end
      cl_sda_ready <= ($urandom_range(3) != 0);
      cl_ocl_ready <= ($urandom_range(3) != 0);
    end
  end

  // Storage credits back only beats it has received
  always @(posedge clk) begin
    if (rst_n) begin
      owed = owed + int'(trace_out.valid) - int'(trace_credit);
      trace_credit <= credit_en && (owed > 0) && ($urandom_range(1) == 1);
      rep_credits = rep_credits + int'(replay_credit);
      check("replay_credit_bound", 65'(1), 65'(rep_credits <= `RR_REPLAY_FIFO_DEPTH));
      if (rep_credits > 0 && feed_q.size() > 0 && $urandom_range(3) != 0) begin
        replay_in.valid <= 1'b1;
        replay_in.word  <= feed_q.pop_front();
        rep_credits--;
      end else begin
        replay_in.valid <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Comparison
  //////////////////////////////
  // Sampled mid-cycle where every output has settled
  always @(negedge clk) begin : compare
    rr_pkg::sda_req_t       exp_sda;
    rr_pkg::ocl_req_t       exp_ocl;
    rr_pkg::rr_trace_word_t exp_word;
    if (rst_n) begin
      if (cl_sda_valid && cl_sda_ready) begin
        if (exp_sda_cl_q.size() == 0) begin
          report_failure("CL sda handshake with no request outstanding");
        end else begin
          exp_sda = exp_sda_cl_q.pop_front();
          check("cl_sda", 65'(exp_sda), 65'(cl_sda_req));
        end
      end
      if (cl_ocl_valid && cl_ocl_ready) begin
        if (exp_ocl_cl_q.size() == 0) begin
          report_failure("CL ocl handshake with no request outstanding");
        end else begin
          exp_ocl = exp_ocl_cl_q.pop_front();
          check("cl_ocl", 65'(exp_ocl), 65'(cl_ocl_req));
        end
      end
      if (trace_out.valid) begin
        beats_seen++;
        if (trace_out.word.chan == rr_pkg::CH_SDA && exp_sda_trace_q.size() != 0) begin
          exp_word = exp_sda_trace_q.pop_front();
          check("trace_sda", 65'(exp_word), 65'(trace_out.word));
        end else if (trace_out.word.chan == rr_pkg::CH_OCL && exp_ocl_trace_q.size() != 0) begin
          exp_word = exp_ocl_trace_q.pop_front();
          check("trace_ocl", 65'(exp_word), 65'(trace_out.word));
        end else begin
          report_failure("Trace beat appeared with no log entry expected on its channel");
        end
      end
      if (trace_credit) begin
        credits_seen++;
      end
      check("trace_credit_limit", 65'(1),
            65'((beats_seen - credits_seen) <= `RR_TRACE_CREDITS));
      if (replay_credit) begin
        credit_pulses++;
      end
      // Shell stays blocked for the whole replay
      if (rep_active) begin
        check("sda_shell_ready_in_replay", 65'(0), 65'(sda_ready));
        check("ocl_shell_ready_in_replay", 65'(0), 65'(ocl_ready));
      end
      if (rec_active && !rep_active &&
          ((sda_valid && cl_sda_ready && !sda_ready) ||
           (ocl_valid && cl_ocl_ready && !ocl_ready))) begin
        stall_seen = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      report_failure($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    void'($urandom(32'hb7d65ac5));
    rst_n        = 1'b0;
    record_en    = 1'b0;
    replay_en    = 1'b0;
    sda_valid    = 1'b0;
    sda_req      = '0;
    ocl_valid    = 1'b0;
    ocl_req      = '0;
    cl_sda_ready = 1'b0;
    cl_ocl_ready = 1'b0;
    trace_credit = 1'b0;
    replay_in    = '0;
    credit_en    = 1'b1;
    rec_active   = 1'b0;
    rep_active   = 1'b0;
    stall_seen   = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Record pass-through and trace contents
    set_mode(1'b1, 1'b0);
    send_shell(N_REC, 1'b1);
    wait_idle();

    // Credits withheld until the log queues back up into the shell
    stall_seen = 1'b0;
    credit_en <= 1'b0;
    send_shell(N_BP, 1'b1);
    for (int i = 0; i < 60 && !stall_seen; i++) begin
      @(posedge clk);
    end
    check("backpressure_stall", 65'(1), 65'(stall_seen));
    credit_en <= 1'b1;
    wait_idle();

    // Replay only and then replay with the CL side recorded again
    set_mode(1'b0, 1'b1);
    feed_replay(N_REP, 1'b1, 1'b0);
    wait_idle();
    set_mode(1'b1, 1'b1);
    feed_replay(N_RR, 1'b0, 1'b1);
    wait_idle();
    check("replay_credit_pulses", 65'(words_fed), 65'(credit_pulses));

    // Recording off so any trace beat is unexpected
    set_mode(1'b0, 1'b0);
    send_shell(N_OFF, 1'b0);
    wait_idle();
    repeat (8) @(posedge clk);

    if (errors == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
logic/rr_pkg.sv
logic/rr_trace_decoder.sv
logic/rr_channel_replayer.sv
logic/rr_channel_recorder.sv
logic/rr_trace_merger.sv
logic/rr_wrapper.sv
testbench/tb_rr_wrapper.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing -Wno-fatal
TOP       ?= tb_rr_wrapper
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status comes from the search for the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
